//--- tests/tcb_lite_stimulus.txt
# columns: op (R/W) address wdata byte-enables expected-rdt expected-err, all hex
# rdt is checked on reads only, err on every transfer
# memory round trip
W 00000000 11223344 f 00000000 0
W 00000004 55667788 f 00000000 0
W 00000ffc deadbeef f 00000000 0
W 00000800 a5a55a5a f 00000000 0
R 00000000 00000000 f 11223344 0
R 00000004 00000000 f 55667788 0
R 00000ffc 00000000 f deadbeef 0
R 00000800 00000000 f a5a55a5a 0
# memory byte enables
W 00000004 000000ee 1 00000000 0
W 00000004 cc000000 8 00000000 0
R 00000004 00000000 f cc6677ee 0
# register block
R 00010004 00000000 f 7c810001 0
R 00010008 00000000 f 00000000 0
W 00010000 12345678 f 00000000 0
W 00010000 0000ab00 2 00000000 0
R 00010000 00000000 f 1234ab78 0
W 00010004 ffffffff f 00000000 1
W 00010008 00000005 f 00000000 1
R 0001000c 00000000 f 00000000 1
W 0001000c 00000001 f 00000000 1
R 00010008 00000000 f 00000002 0
R 00010004 00000000 f 7c810001 0
# unmapped addresses
R 00020000 00000000 f 00000000 1
W 00001000 12121212 f 00000000 1
R 00010010 00000000 f 00000000 1
R 00000000 00000000 f 11223344 0
# alternating memory and registers
R 00000ffc 00000000 f deadbeef 0
R 00010000 00000000 f 1234ab78 0
W 00000010 0badf00d f 00000000 0
R 00010008 00000000 f 00000002 0
R 00000010 00000000 f 0badf00d 0
W 00010000 cafef00d f 00000000 0
R 00000004 00000000 f cc6677ee 0
R 00010000 00000000 f cafef00d 0
R 00000800 00000000 f a5a55a5a 0
R 00010008 00000000 f 00000003 0

//--- all.f
hdl/tcb_lite_pkg.sv
hdl/tcb_lite_decoder.sv
hdl/tcb_lite_demultiplexer.sv
hdl/tcb_lite_memory.sv
hdl/tcb_lite_registers.sv
hdl/tcb_lite_subsystem.sv
tests/tcb_lite_subsystem_tb.sv

//--- Bender.yml
package:
  name: tcb_lite_subsystem

sources:
  # RTL in compile order
  - files:
      - hdl/tcb_lite_pkg.sv
      - hdl/tcb_lite_decoder.sv
      - hdl/tcb_lite_demultiplexer.sv
      - hdl/tcb_lite_memory.sv
      - hdl/tcb_lite_registers.sv
      - hdl/tcb_lite_subsystem.sv

  # testbench
  - target: test
    files:
      - tests/tcb_lite_subsystem_tb.sv

//--- tests/tcb_lite_subsystem_tb.sv
// TCB-Lite subsystem testbench
// reads transfers and expected responses from the stimulus file,
// drives the upstream port with random idle gaps and checks rdt
// and err of every response one cycle after each transfer, and
// the number of stall cycles seen on up_rdy

`timescale 1ns/10ps

module tcb_lite_subsystem_tb;

    // one transfer of the stimulus file
    typedef struct packed {
        logic [7:0]                     op;
        logic [tcb_lite_pkg::ADR_W-1:0] adr;
        logic [tcb_lite_pkg::DAT_W-1:0] wdt;
        logic [tcb_lite_pkg::BYT_W-1:0] byt;
        logic [tcb_lite_pkg::DAT_W-1:0] rdt;
        logic                           err;
    } vector_t;

    // DUT ports
    logic                   sub    = 1'b0;
    logic                   rst    = 1'b1;
    logic                   up_vld = 1'b0;
    tcb_lite_pkg::tcb_req_t up_req = '0;
    logic                   up_rdy;
    tcb_lite_pkg::tcb_rsp_t up_rsp;

    vector_t vectors [$];

    // error counters
    int  n_checks   = 0;
    int  n_rdt_err  = 0;
    int  n_err_err  = 0;
    int  n_rdy_err  = 0;
    int  n_timeout  = 0;
    int  n_file_err = 0;
    bit  timed_out  = 1'b0;

    tcb_lite_subsystem tcb_lite_subsystem_i (
        .sub    (sub),
        .rst    (rst),
        .up_vld (up_vld),
        .up_req (up_req),
        .up_rdy (up_rdy),
        .up_rsp (up_rsp)
    );

    // 10 ns period
    always #5 sub = ~sub;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // 0 memory, 1 registers, 2 unmapped
    function automatic int window_of(input logic [tcb_lite_pkg::ADR_W-1:0] adr);
        if (adr >= tcb_lite_pkg::MEM_BASE &&
            adr < tcb_lite_pkg::MEM_BASE + tcb_lite_pkg::MEM_SIZE) begin
            return 0;
        end
        if (adr >= tcb_lite_pkg::REG_BASE &&
            adr < tcb_lite_pkg::REG_BASE + tcb_lite_pkg::REG_SIZE) begin
            return 1;
        end
        return 2;
    endfunction

    // parse the stimulus file, '#' lines are comments
    task automatic load_vectors();
        int                             fd;
        int                             c;
        int                             n;
        logic [tcb_lite_pkg::ADR_W-1:0] adr;
        logic [tcb_lite_pkg::DAT_W-1:0] wdt;
        logic [tcb_lite_pkg::BYT_W-1:0] byt;
        logic [tcb_lite_pkg::DAT_W-1:0] rdt;
        logic                           err;
        vector_t                        v;
        fd = $fopen("tests/tcb_lite_stimulus.txt", "r");
        if (fd == 0) begin
            $display("the stimulus file could not be opened");
            n_file_err++;
        end else begin
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    // skip the rest of the line
                    while (c != -1 && c != "\n") begin
                        c = $fgetc(fd);
                    end
                end else if (c == "R" || c == "W") begin
                    n = $fscanf(fd, "%h %h %h %h %h", adr, wdt, byt, rdt, err);
                    if (n != 5) begin
                        $display("a stimulus line could not be parsed");
                        n_file_err++;
                    end else begin
                        v.op  = c[7:0];
                        v.adr = adr;
                        v.wdt = wdt;
                        v.byt = byt;
                        v.rdt = rdt;
                        v.err = err;
                        vectors.push_back(v);
                    end
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // called on a falling edge, returns on the falling edge of the response cycle
    task automatic run_transfer(input vector_t v, output tcb_lite_pkg::tcb_rsp_t rsp,
                                output int stalls);
        int                     waited;
        tcb_lite_pkg::tcb_req_t req;
        req.wen = (v.op == "W");
        req.ren = (v.op == "R");
        req.adr = v.adr;
        req.byt = v.byt;
        req.wdt = v.wdt;
        up_req  = req;
        up_vld  = 1'b1;
        waited  = 0;
        // rdy sampled well inside the low phase
        #1;
        while (!up_rdy && waited < 20) begin
            @(negedge sub);
            #1;
            waited++;
        end
        stalls = waited;
        if (!up_rdy) begin
            $display("transfer to address %h was not accepted within 20 cycles", v.adr);
            n_timeout++;
            timed_out = 1'b1;
            up_vld    = 1'b0;
            rsp       = '0;
        end else begin
            // transfer on this edge, response in the following cycle
            @(posedge sub);
            @(negedge sub);
            up_vld = 1'b0;
            rsp    = up_rsp;
        end
    endtask

    // rdt only meaningful on reads
    task automatic check_response(input vector_t v, input tcb_lite_pkg::tcb_rsp_t rsp);
        n_checks++;
        if (v.op == "R") begin
            assert (rsp.rdt === v.rdt) else begin
                n_rdt_err++;
                $display("** Error: up_rsp.rdt = %h, expected %h, address %h",
                         rsp.rdt, v.rdt, v.adr);
            end
        end
        assert (rsp.err === v.err) else begin
            n_err_err++;
            $display("** Error: up_rsp.err = %h, expected %h, address %h",
                     rsp.err, v.err, v.adr);
        end
    endtask

    // cycles with up_rdy low before the transfer was taken
    task automatic check_stalls(input vector_t v, input int stalls, input int exp_stalls);
        assert (stalls == exp_stalls) else begin
            n_rdy_err++;
            $display("** Error: up_rdy stall cycles = %h, expected %h, address %h",
                     stalls, exp_stalls, v.adr);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : main
        tcb_lite_pkg::tcb_rsp_t rsp;
        int                     prev_win;
        int                     gap;
        int                     stalls;
        int                     exp_stalls;
        void'($urandom(32'hf31f_877b));
        load_vectors();
        if (vectors.size() == 0) begin
            $display("no transfers were found in the stimulus file");
            n_file_err++;
        end
        // reset over four rising edges
        repeat (4) @(negedge sub);
        rst      = 1'b0;
        prev_win = -1;
        for (int i = 0; i < vectors.size() && !timed_out; i++) begin
            // no gap when switching subordinates, so alternating runs go back to back
            if (window_of(vectors[i].adr) != prev_win) begin
                gap = 0;
            end else begin
                gap = $urandom_range(2, 0);
            end
            // registers hold rdy low in the cycle right after their own transfer
            if (window_of(vectors[i].adr) == 1 && prev_win == 1 && gap == 0) begin
                exp_stalls = 1;
            end else begin
                exp_stalls = 0;
            end
            repeat (gap) @(negedge sub);
            run_transfer(vectors[i], rsp, stalls);
            if (!timed_out) begin
                check_response(vectors[i], rsp);
                check_stalls(vectors[i], stalls, exp_stalls);
            end
            prev_win = window_of(vectors[i].adr);
        end
        $display("checks %0d, rdt errors %0d, err errors %0d, rdy errors %0d, %s %0d, %s %0d",
                 n_checks, n_rdt_err, n_err_err, n_rdy_err,
                 "timeouts", n_timeout, "file errors", n_file_err);
        if (n_rdt_err + n_err_err + n_rdy_err + n_timeout + n_file_err == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- hdl/tcb_lite_subsystem.sv
// TCB-Lite subsystem
// one upstream manager port reaching a word memory and a register
// block through the address decoder and the demultiplexer

`timescale 1ns/10ps

module tcb_lite_subsystem (
    input  logic                    sub,
    input  logic                    rst,
    input  logic                    up_vld,
    input  tcb_lite_pkg::tcb_req_t  up_req,
    output logic                    up_rdy,
    output tcb_lite_pkg::tcb_rsp_t  up_rsp
);

    // decoder to demultiplexer
    logic                           mid_vld;
    tcb_lite_pkg::tcb_req_t         mid_req;
    logic                           mid_rdy;
    tcb_lite_pkg::tcb_rsp_t         mid_rsp;
    logic [tcb_lite_pkg::SUB_L-1:0] sel;

    // demultiplexer to subordinates
    logic                   dn_vld [tcb_lite_pkg::SUB_N-1:0];
    tcb_lite_pkg::tcb_req_t dn_req [tcb_lite_pkg::SUB_N-1:0];
    logic                   dn_rdy [tcb_lite_pkg::SUB_N-1:0];
    tcb_lite_pkg::tcb_rsp_t dn_rsp [tcb_lite_pkg::SUB_N-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // interconnect
    ////////////////////////////////////////////////////////////////////////////

    tcb_lite_decoder tcb_lite_decoder_i (
        .sub     (sub),
        .rst     (rst),
        .up_vld  (up_vld),
        .up_req  (up_req),
        .up_rdy  (up_rdy),
        .up_rsp  (up_rsp),
        .mid_vld (mid_vld),
        .mid_req (mid_req),
        .mid_rdy (mid_rdy),
        .mid_rsp (mid_rsp),
        .sel     (sel)
    );

    tcb_lite_demultiplexer #(
        .IFN (tcb_lite_pkg::SUB_N)
    ) tcb_lite_demultiplexer_i (
        .sub    (sub),
        .rst    (rst),
        .sel    (sel),
        .up_vld (mid_vld),
        .up_req (mid_req),
        .up_rdy (mid_rdy),
        .up_rsp (mid_rsp),
        .dn_vld (dn_vld),
        .dn_req (dn_req),
        .dn_rdy (dn_rdy),
        .dn_rsp (dn_rsp)
    );

    ////////////////////////////////////////////////////////////////////////////
    // subordinates
    ////////////////////////////////////////////////////////////////////////////

    tcb_lite_memory tcb_lite_memory_i (
        .sub (sub),
        .vld (dn_vld[tcb_lite_pkg::MEM_IDX]),
        .req (dn_req[tcb_lite_pkg::MEM_IDX]),
        .rdy (dn_rdy[tcb_lite_pkg::MEM_IDX]),
        .rsp (dn_rsp[tcb_lite_pkg::MEM_IDX])
    );

    tcb_lite_registers tcb_lite_registers_i (
        .sub (sub),
        .rst (rst),
        .vld (dn_vld[tcb_lite_pkg::REG_IDX]),
        .req (dn_req[tcb_lite_pkg::REG_IDX]),
        .rdy (dn_rdy[tcb_lite_pkg::REG_IDX]),
        .rsp (dn_rsp[tcb_lite_pkg::REG_IDX])
    );

endmodule

//--- hdl/tcb_lite_registers.sv
// TCB-Lite control registers
// scratch (read-write), ID (read-only) and write counter (read-only);
// illegal accesses answer with err, and the block stalls one cycle
// after each accepted transfer

`timescale 1ns/10ps

module tcb_lite_registers (
    input  logic                    sub,
    input  logic                    rst,
    input  logic                    vld,
    input  tcb_lite_pkg::tcb_req_t  req,
    output logic                    rdy,
    output tcb_lite_pkg::tcb_rsp_t  rsp
);

    logic [$clog2(tcb_lite_pkg::REG_SIZE)-1:2] ofs;
    logic                                      trn;
    logic                                      acc_err;
    logic                                      wr_ok;
    logic [tcb_lite_pkg::DAT_W-1:0]            rd_val;
    logic [tcb_lite_pkg::DAT_W-1:0]            scratch;
    logic [tcb_lite_pkg::DAT_W-1:0]            wcount;
    logic [tcb_lite_pkg::DAT_W-1:0]            rdt_q;
    logic                                      err_q;
    logic                                      rdy_q;

    assign trn = vld & rdy_q;
    // word offset in the window
    assign ofs = req.adr[$clog2(tcb_lite_pkg::REG_SIZE)-1:2];

    ////////////////////////////////////////////////////////////////////////////
    // decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        acc_err = 1'b0;
        rd_val  = '0;
        case (ofs)
            tcb_lite_pkg::REG_SCRATCH: rd_val = scratch;
            tcb_lite_pkg::REG_ID: begin
                rd_val  = tcb_lite_pkg::REG_ID_VALUE;
                acc_err = req.wen;
            end
            tcb_lite_pkg::REG_WCOUNT: begin
                rd_val  = wcount;
                acc_err = req.wen;
            end
            // offset 3, nothing there
            default: acc_err = 1'b1;
        endcase
    end

    // only scratch writes get through
    assign wr_ok = trn & req.wen & ~acc_err;

    ////////////////////////////////////////////////////////////////////////////
    // state
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge sub) begin
        if (rst) begin
            scratch <= '0;
            wcount  <= '0;
            err_q   <= 1'b0;
            rdy_q   <= 1'b1;
        end else begin
            // one stall cycle after each transfer
            rdy_q <= ~trn;
            if (trn) begin
                err_q <= acc_err;
            end
            if (wr_ok) begin
                for (int b = 0; b < tcb_lite_pkg::BYT_W; b++) begin
                    if (req.byt[b]) begin
                        scratch[8*b +: 8] <= req.wdt[8*b +: 8];
                    end
                end
                // wraps at 2^32
                wcount <= wcount + 1'b1;
            end
        end
    end

    // zero on errors and on write-only transfers
    always_ff @(posedge sub) begin
        if (trn) begin
            rdt_q <= (req.ren & ~acc_err) ? rd_val : '0;
        end
    end

    assign rdy     = rdy_q;
    assign rsp.rdt = rdt_q;
    assign rsp.err = err_q;

endmodule

//--- hdl/tcb_lite_memory.sv
// TCB-Lite word memory
// single-port memory of MEM_DEPTH words with byte-enable writes;
// always ready, read data registered for the one cycle response

`timescale 1ns/10ps

module tcb_lite_memory (
    input  logic                    sub,
    input  logic                    vld,
    input  tcb_lite_pkg::tcb_req_t  req,
    output logic                    rdy,
    output tcb_lite_pkg::tcb_rsp_t  rsp
);

    ////////////////////////////////////////////////////////////////////////////
    // storage
    ////////////////////////////////////////////////////////////////////////////

    logic [tcb_lite_pkg::DAT_W-1:0]             mem [0:tcb_lite_pkg::MEM_DEPTH-1];
    logic [$clog2(tcb_lite_pkg::MEM_DEPTH)-1:0] mem_adr;
    logic [tcb_lite_pkg::DAT_W-1:0]             rdt_q;
    logic                                       trn;

    // no wait states
    assign rdy = 1'b1;
    assign trn = vld & rdy;

    // word index within the window, byte offset dropped
    assign mem_adr = req.adr[$clog2(tcb_lite_pkg::MEM_SIZE)-1:2];

    ////////////////////////////////////////////////////////////////////////////
    // write
    ////////////////////////////////////////////////////////////////////////////

    // only enabled bytes are updated
    always_ff @(posedge sub) begin
        if (trn && req.wen) begin
            for (int b = 0; b < tcb_lite_pkg::BYT_W; b++) begin
                if (req.byt[b]) begin
                    mem[mem_adr][8*b +: 8] <= req.wdt[8*b +: 8];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // read
    ////////////////////////////////////////////////////////////////////////////

    // old contents on a read during write
    always_ff @(posedge sub) begin
        if (trn && req.ren) begin
            rdt_q <= mem[mem_adr];
        end
    end

    // memory never signals an error
    assign rsp.rdt = rdt_q;
    assign rsp.err = 1'b0;

    // every response from this block is error free
    a_no_err: assert property (
        @(posedge sub) vld && rdy |=> !rsp.err
    ) else $error("memory returned an error");

endmodule

//--- hdl/tcb_lite_demultiplexer.sv
// TCB-Lite demultiplexer
// one upstream port to IFN downstream ports; the request goes to the
// port given by sel, the response is taken from the port that
// accepted the previous transfer (fixed one cycle delay)

`timescale 1ns/10ps

module tcb_lite_demultiplexer #(
    parameter int unsigned IFN = tcb_lite_pkg::SUB_N
)(
    input  logic                            sub,
    input  logic                            rst,
    // port select, valid together with up_vld
    input  logic [tcb_lite_pkg::SUB_L-1:0]  sel,
    // upstream, manager side
    input  logic                            up_vld,
    input  tcb_lite_pkg::tcb_req_t          up_req,
    output logic                            up_rdy,
    output tcb_lite_pkg::tcb_rsp_t          up_rsp,
    // downstream, subordinate side
    output logic                            dn_vld [IFN-1:0],
    output tcb_lite_pkg::tcb_req_t          dn_req [IFN-1:0],
    input  logic                            dn_rdy [IFN-1:0],
    input  tcb_lite_pkg::tcb_rsp_t          dn_rsp [IFN-1:0]
);

    ////////////////////////////////////////////////////////////////////////////
    // control
    ////////////////////////////////////////////////////////////////////////////

    logic                           trn;
    logic [tcb_lite_pkg::SUB_L-1:0] rsp_sel;

    // transfer on the upstream port
    assign trn = up_vld & up_rdy;

    // response select follows the request select by one transfer
    always_ff @(posedge sub) begin
        if (rst) begin
            rsp_sel <= tcb_lite_pkg::MEM_IDX;
        end else if (trn) begin
            rsp_sel <= sel;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // request
    ////////////////////////////////////////////////////////////////////////////

    // vld only to the selected port, payload to all of them
    for (genvar i = 0; i < IFN; i++) begin : gen_req
        assign dn_vld[i] = (int'(sel) == i) ? up_vld : 1'b0;
        assign dn_req[i] = up_req;
    end

    ////////////////////////////////////////////////////////////////////////////
    // response
    ////////////////////////////////////////////////////////////////////////////

    // back-pressure from the current target
    assign up_rdy = dn_rdy[sel];

    // response from the target of the previous transfer
    assign up_rsp = dn_rsp[rsp_sel];

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // a stalled request must be held by the manager
    a_req_stable: assert property (
        @(posedge sub) disable iff (rst) up_vld && !up_rdy |=> $stable(up_req)
    ) else $error("request changed while stalled");

    // select must name an existing port
    a_sel_range: assert property (
        @(posedge sub) disable iff (rst) up_vld |-> int'(sel) < IFN
    ) else $error("select %0d out of range", sel);

endmodule

//--- hdl/tcb_lite_decoder.sv
// TCB-Lite address decoder
// maps the manager address onto a subordinate index and answers
// addresses outside both windows with a bus error of its own

`timescale 1ns/10ps

module tcb_lite_decoder (
    input  logic                                sub,
    input  logic                                rst,
    input  logic                                up_vld,
    input  tcb_lite_pkg::tcb_req_t              up_req,
    output logic                                up_rdy,
    output tcb_lite_pkg::tcb_rsp_t              up_rsp,
    output logic                                mid_vld,
    output tcb_lite_pkg::tcb_req_t              mid_req,
    input  logic                                mid_rdy,
    input  tcb_lite_pkg::tcb_rsp_t              mid_rsp,
    output logic [tcb_lite_pkg::SUB_L-1:0]      sel
);

    logic hit_mem;
    logic hit_reg;
    logic miss;
    logic miss_q;

    // window compare, base aligned to size
    assign hit_mem = (up_req.adr & tcb_lite_pkg::MEM_MASK) == tcb_lite_pkg::MEM_BASE;
    assign hit_reg = (up_req.adr & tcb_lite_pkg::REG_MASK) == tcb_lite_pkg::REG_BASE;
    assign miss    = ~hit_mem & ~hit_reg;

    // request path, blocked on a miss
    assign sel     = hit_reg ? tcb_lite_pkg::REG_IDX : tcb_lite_pkg::MEM_IDX;
    assign mid_vld = up_vld & ~miss;
    assign mid_req = up_req;
    // a miss is taken at once
    assign up_rdy  = miss ? 1'b1 : mid_rdy;

    // remember the miss for the response cycle
    always_ff @(posedge sub) begin
        if (rst) begin
            miss_q <= 1'b0;
        end else begin
            miss_q <= up_vld & miss;
        end
    end

    // error response replaces whatever the demultiplexer shows
    always_comb begin
        up_rsp = mid_rsp;
        if (miss_q) begin
            up_rsp.rdt = '0;
            up_rsp.err = 1'b1;
        end
    end

    // the two windows never overlap for a transfer
    a_no_double_hit: assert property (
        @(posedge sub) disable iff (rst) up_vld && up_rdy |-> !(hit_mem && hit_reg)
    ) else $error("address %h hits both windows", up_req.adr);

endmodule

//--- hdl/tcb_lite_pkg.sv
// TCB-Lite shared definitions
// bus widths, request and response structs, the subordinate
// address map and the register block offsets used by the
// two-subordinate interconnect

package tcb_lite_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // bus widths
    ////////////////////////////////////////////////////////////////////////////

    // byte address
    localparam int unsigned ADR_W = 32;
    // data word
    localparam int unsigned DAT_W = 32;
    // one enable per data byte
    localparam int unsigned BYT_W = DAT_W / 8;

    ////////////////////////////////////////////////////////////////////////////
    // request and response
    ////////////////////////////////////////////////////////////////////////////

    // manager to subordinate, 70 bits
    typedef struct packed {
        logic             wen;  // write enable
        logic             ren;  // read enable
        logic [ADR_W-1:0] adr;  // byte address
        logic [BYT_W-1:0] byt;  // byte enables
        logic [DAT_W-1:0] wdt;  // write data
    } tcb_req_t;

    // subordinate to manager, 33 bits, valid one cycle after transfer
    typedef struct packed {
        logic [DAT_W-1:0] rdt;  // read data
        logic             err;  // bus error
    } tcb_rsp_t;

    ////////////////////////////////////////////////////////////////////////////
    // subordinates and address map
    ////////////////////////////////////////////////////////////////////////////

    localparam int unsigned SUB_N = 2;
    localparam int unsigned SUB_L = 1;

    // demultiplexer port indices
    localparam logic [SUB_L-1:0] MEM_IDX = 1'd0;
    localparam logic [SUB_L-1:0] REG_IDX = 1'd1;

    // memory window, size in bytes and a power of two
    localparam logic [ADR_W-1:0] MEM_BASE = 32'h0000_0000;
    localparam int unsigned      MEM_SIZE = 4096;
    localparam logic [ADR_W-1:0] MEM_MASK = ~(ADR_W'(MEM_SIZE - 1));

    // register window, four words
    localparam logic [ADR_W-1:0] REG_BASE = 32'h0001_0000;
    localparam int unsigned      REG_SIZE = 16;
    localparam logic [ADR_W-1:0] REG_MASK = ~(ADR_W'(REG_SIZE - 1));

    // memory depth in words
    localparam int unsigned MEM_DEPTH = MEM_SIZE / 4;

    ////////////////////////////////////////////////////////////////////////////
    // register block
    ////////////////////////////////////////////////////////////////////////////

    // word offsets within the register window, offset 3 unmapped
    localparam int unsigned REG_SCRATCH = 0;
    localparam int unsigned REG_ID      = 1;
    localparam int unsigned REG_WCOUNT  = 2;

    // read-only identification word
    localparam logic [DAT_W-1:0] REG_ID_VALUE = 32'h7c81_0001;

endpackage
